/* Bender.yml */
package:
  name: rv32e_core

export_include_dirs:
  - .

sources:
  - rv32e_pkg.sv
  - rv32e_alu.sv
  - rv32e_regfile.sv
  - rv32e_fetch.sv
  - rv32e_decode.sv
  - rv32e_execute.sv
  - rv32e_mem_wb.sv
  - rv32e_core.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_rv32e_core.sv

/* rv32e_alu.sv */
// RV32E integer ALU
// Purely combinational, RV32I base operations plus operand B pass-through
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_alu (
    input  rv32e_pkg::alu_op_e  op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] result_o
);

    import rv32e_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt;
            SLT:     result_o = {{(`RV_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            SLTU:    result_o = {{(`RV_XLEN-1){1'b0}}, a_i < b_i};
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = $unsigned($signed(a_i) >>> shamt);
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            PASS_B:  result_o = b_i;
            default: result_o = '0;  // Unused encodings
        endcase
    end

endmodule

/* rv32e_core.sv */
// RV32E five-stage pipeline top level
// Wires fetch, decode, execute and memory/writeback together
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`RV_XLEN-1:0]  instr_data_i,
    output logic [`RV_XLEN-1:0]  instr_addr_o,
    input  logic [`RV_XLEN-1:0]  dmem_rdata_i,
    output rv32e_pkg::dmem_req_t dmem_req_o
);

    import rv32e_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     mem_fwd;  // Combinational memory-stage result
    wb_t     wb;       // MEM/WB register, also the RF write port

    rv32e_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_data_i(instr_data_i),
        .instr_addr_o(instr_addr_o),
        .if_id_o     (if_id)
    );

    rv32e_decode u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .if_id_i(if_id),
        .wb_i   (wb),
        .id_ex_o(id_ex)
    );

    rv32e_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex_i  (id_ex),
        .mem_fwd_i(mem_fwd),
        .wb_i     (wb),
        .ex_mem_o (ex_mem)
    );

    rv32e_mem_wb u_mem_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem_i    (ex_mem),
        .dmem_rdata_i(dmem_rdata_i),
        .dmem_req_o  (dmem_req_o),
        .mem_fwd_o   (mem_fwd),
        .wb_o        (wb)
    );

endmodule

/* rv32e_decode.sv */
// RV32E decode stage
// Control decode, immediate generation, register read and the ID/EX register
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  rv32e_pkg::if_id_t if_id_i,
    input  rv32e_pkg::wb_t    wb_i,
    output rv32e_pkg::id_ex_t id_ex_o
);

    import rv32e_pkg::*;

    logic [`RV_XLEN-1:0] instr;
    opcode_e             opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    reg_addr_t           rd;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                use_imm;
    logic                mem_we;
    logic                mem_re;
    logic                reg_we;

    // Bit 30 picks SUB only for register ops, SRA for both forms
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        case (f3)
            3'b000:  return (alt && is_reg) ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign instr     = if_id_i.instr;
    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd        = instr[10:7];   // Upper index bit unused in RV32E
    assign rs1       = instr[18:15];
    assign rs2       = instr[23:20];

    always_comb begin
        alu_op  = ADD;
        use_imm = 1'b0;
        mem_we  = 1'b0;
        mem_re  = 1'b0;
        reg_we  = 1'b0;
        imm     = '0;
        case (opcode)
            OP_REG: begin
                alu_op = funct_to_alu(funct3, funct7_b5, 1'b1);
                reg_we = 1'b1;
            end
            OP_IMM: begin
                alu_op  = funct_to_alu(funct3, funct7_b5, 1'b0);
                use_imm = 1'b1;
                reg_we  = 1'b1;
                imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
            end
            OP_LOAD: begin
                use_imm = 1'b1;  // Address is rs1 + I immediate
                mem_re  = 1'b1;
                reg_we  = 1'b1;
                imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                use_imm = 1'b1;
                mem_we  = 1'b1;
                imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_LUI: begin
                alu_op  = PASS_B;
                use_imm = 1'b1;
                reg_we  = 1'b1;
                imm     = {instr[31:12], 12'b0};
            end
            default: ;  // Anything else retires as a NOP
        endcase
    end

    rv32e_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .wb_i      (wb_i),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o <= '0;  // All enables low, behaves as a NOP
        end else begin
            id_ex_o.rs1      <= rs1;
            id_ex_o.rs2      <= rs2;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            id_ex_o.rd       <= rd;
            id_ex_o.imm      <= imm;
            id_ex_o.alu_op   <= alu_op;
            id_ex_o.use_imm  <= use_imm;
            id_ex_o.mem_we   <= mem_we;
            id_ex_o.mem_re   <= mem_re;
            id_ex_o.reg_we   <= reg_we;
        end
    end

endmodule

/* rv32e_defs.svh */
// RV32E core constants
// Data width, register count, reset vector and NOP encoding
`ifndef RV32E_DEFS_SVH
`define RV32E_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// RV32E has sixteen integer registers
`define RV_NREGS 16

// First fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

/* rv32e_execute.sv */
// RV32E execute stage
// Operand forwarding and select, ALU and the EX/MEM register
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  rv32e_pkg::id_ex_t  id_ex_i,
    input  rv32e_pkg::wb_t     mem_fwd_i,
    input  rv32e_pkg::wb_t     wb_i,
    output rv32e_pkg::ex_mem_t ex_mem_o
);

    import rv32e_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;

    // Youngest producer wins, x0 is never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_sel(input reg_addr_t rs,
                                                    input logic [`RV_XLEN-1:0] rf_data,
                                                    input wb_t mem_fwd, input wb_t wb);
        if (rs == '0) begin
            return rf_data;
        end else if (mem_fwd.reg_we && mem_fwd.rd == rs) begin
            return mem_fwd.data;
        end else if (wb.reg_we && wb.rd == rs) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign op_a    = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_data, mem_fwd_i, wb_i);
    assign rs2_val = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_data, mem_fwd_i, wb_i);
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    rv32e_alu u_alu (
        .op_i    (id_ex_i.alu_op),
        .a_i     (op_a),
        .b_i     (op_b),
        .result_o(alu_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.result     <= alu_result;
            ex_mem_o.store_data <= rs2_val;  // SW data after forwarding
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.mem_we     <= id_ex_i.mem_we;
            ex_mem_o.mem_re     <= id_ex_i.mem_re;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
        end
    end

endmodule

/* rv32e_fetch.sv */
// RV32E fetch stage
// Sequential program counter and the IF/ID register
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`RV_XLEN-1:0] instr_data_i,
    output logic [`RV_XLEN-1:0] instr_addr_o,
    output rv32e_pkg::if_id_t   if_id_o
);

    logic [`RV_XLEN-1:0] pc_q;

    assign instr_addr_o = pc_q;  // Memory answers in the same cycle

    // No redirects, so the PC only ever steps forward
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q          <= `RV_RESET_PC;
            if_id_o.instr <= `RV_NOP;
            if_id_o.pc    <= `RV_RESET_PC;
        end else begin
            pc_q          <= pc_q + `RV_XLEN'(4);
            if_id_o.instr <= instr_data_i;
            if_id_o.pc    <= pc_q;
        end
    end

endmodule

/* rv32e_mem_wb.sv */
// RV32E memory stage
// Data memory request, load/result select and the MEM/WB register
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_mem_wb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32e_pkg::ex_mem_t   ex_mem_i,
    input  logic [`RV_XLEN-1:0]  dmem_rdata_i,
    output rv32e_pkg::dmem_req_t dmem_req_o,
    output rv32e_pkg::wb_t       mem_fwd_o,
    output rv32e_pkg::wb_t       wb_o
);

    assign dmem_req_o.addr  = ex_mem_i.result;
    assign dmem_req_o.wdata = ex_mem_i.store_data;
    assign dmem_req_o.we    = ex_mem_i.mem_we;
    assign dmem_req_o.re    = ex_mem_i.mem_re;

    // Load data returns this cycle, so it can be forwarded straight away
    assign mem_fwd_o.rd     = ex_mem_i.rd;
    assign mem_fwd_o.data   = ex_mem_i.mem_re ? dmem_rdata_i : ex_mem_i.result;
    assign mem_fwd_o.reg_we = ex_mem_i.reg_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_o <= '0;
        end else begin
            wb_o <= mem_fwd_o;
        end
    end

endmodule

/* rv32e_pkg.sv */
// RV32E shared types
// Opcode and ALU encodings plus the records passed between pipeline stages
`include "rv32e_defs.svh"

package rv32e_pkg;

    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    // Only the opcodes this core executes
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    // Encoded as {funct7[5], funct3} where the ISA allows it
    typedef enum logic [3:0] {
        ADD    = 4'b0000,
        SLL    = 4'b0001,
        SLT    = 4'b0010,
        SLTU   = 4'b0011,
        XOR    = 4'b0100,
        SRL    = 4'b0101,
        OR     = 4'b0110,
        AND    = 4'b0111,
        SUB    = 4'b1000,
        SRA    = 4'b1101,
        PASS_B = 4'b1111  // LUI, operand B straight through
    } alu_op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        reg_addr_t           rs1;
        reg_addr_t           rs2;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        reg_addr_t           rd;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic                use_imm;
        logic                mem_we;
        logic                mem_re;
        logic                reg_we;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] result;     // ALU result or memory address
        logic [`RV_XLEN-1:0] store_data;
        reg_addr_t           rd;
        logic                mem_we;
        logic                mem_re;
        logic                reg_we;
    } ex_mem_t;

    // Register write record, also the MEM/WB register
    typedef struct packed {
        reg_addr_t           rd;
        logic [`RV_XLEN-1:0] data;
        logic                reg_we;
    } wb_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                we;
        logic                re;
    } dmem_req_t;

endpackage

/* rv32e_regfile.sv */
// RV32E register file
// Sixteen words, x0 reads zero, a same-cycle write is bypassed to the reads
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module rv32e_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32e_pkg::reg_addr_t rs1_i,
    input  rv32e_pkg::reg_addr_t rs2_i,
    input  rv32e_pkg::wb_t       wb_i,
    output logic [`RV_XLEN-1:0]  rs1_data_o,
    output logic [`RV_XLEN-1:0]  rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    assign wr_en = wb_i.reg_we && (wb_i.rd != '0);  // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Write-through covers the writeback three instructions back
    assign rs1_data_o = (wr_en && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (wr_en && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

endmodule

/* tb.f */
+incdir+.
rv32e_pkg.sv
rv32e_alu.sv
rv32e_regfile.sv
rv32e_fetch.sv
rv32e_decode.sv
rv32e_execute.sv
rv32e_mem_wb.sv
rv32e_core.sv
tb_clk_gen.sv
tb_rv32e_core.sv

/* tb_clk_gen.sv */
// Testbench clock and reset source
// 20 ns clock, active-low reset held for the first 8 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #2 rst_n_o = 1'b1;  // Released just after an edge
    end

endmodule

/* tb_rv32e_core.sv */
// RV32E core testbench
// Builds a small program with a register model, serves both memories
// and checks every data-memory store against the model
`timescale 1ns/1ps
`include "rv32e_defs.svh"

module tb_rv32e_core;

    import rv32e_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int ST_BASE    = 'h100;  // Stores land above the loaded words

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_data;
    logic [31:0] instr_addr;
    logic [31:0] dmem_rdata;
    dmem_req_t   dmem_req;

    logic [31:0] prog [64];
    logic [31:0] dmem [128];
    logic [31:0] xreg [16];          // Architectural register model
    logic [31:0] word_idx;
    int          prog_len = 0;
    int          st_off;
    integer      seed;
    bit          build_done = 1'b0;
    string       exp_name_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] pc_exp;
    int          cyc;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    rv32e_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_data_i(instr_data),
        .instr_addr_o(instr_addr),
        .dmem_rdata_i(dmem_rdata),
        .dmem_req_o  (dmem_req)
    );

    // Both memories answer in the same cycle
    assign word_idx   = (instr_addr - `RV_RESET_PC) >> 2;
    assign instr_data = (word_idx < prog_len) ? prog[word_idx] : `RV_NOP;
    assign dmem_rdata = dmem[dmem_req.addr[8:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_req.we) begin
            dmem[dmem_req.addr[8:2]] <= dmem_req.wdata;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        report_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [11:0] imm, input logic [4:0] rd,
                                           input logic [4:0] rs1);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // RV32I semantics by funct3, alt is instruction bit 30
    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)))
                                : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put_instr(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic alu_rr(input logic [2:0] f3, input logic alt, input int rd,
                          input int rs1, input int rs2);
        put_instr(r_type(f3, alt, 5'(rd), 5'(rs1), 5'(rs2)));
        if (rd != 0) xreg[rd] = expected_alu(f3, alt, xreg[rs1], xreg[rs2]);
    endtask

    task automatic alu_ri(input logic [2:0] f3, input logic [11:0] imm, input int rd,
                          input int rs1);
        logic alt;
        alt = (f3 == 3'b101) && imm[10];  // Only SRAI uses bit 30
        put_instr(i_type(7'b0010011, f3, imm, 5'(rd), 5'(rs1)));
        if (rd != 0) xreg[rd] = expected_alu(f3, alt, xreg[rs1], {{20{imm[11]}}, imm});
    endtask

    task automatic load_word(input int rd, input logic [11:0] off);
        put_instr(i_type(7'b0000011, 3'b010, off, 5'(rd), 5'd0));
        if (rd != 0) xreg[rd] = dmem[off[8:2]];
    endtask

    task automatic load_upper(input int rd, input logic [19:0] imm);
        put_instr({imm, 5'(rd), 7'b0110111});
        if (rd != 0) xreg[rd] = {imm, 12'h000};
    endtask

    task automatic store_word(input string name, input int rs2);
        put_instr(s_type(12'(st_off), 5'd0, 5'(rs2)));
        exp_name_q.push_back(name);
        exp_addr_q.push_back(32'(st_off));
        exp_data_q.push_back(xreg[rs2]);
        st_off += 4;
    endtask

    task automatic build_program();
        string       r_names [8] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};
        logic [11:0] i_imm [8]   = '{12'h5a3, 12'h007, 12'hf9c, 12'h800,
                                     12'hfff, 12'h00d, 12'h0f0, 12'h8f1};
        // ALU operations on two random words
        load_word(1, 12'h000);
        load_word(2, 12'h004);
        for (int f = 0; f < 8; f++) begin
            alu_rr(3'(f), 1'b0, 3, 1, 2);
            store_word(r_names[f], 3);  // Store data forwarded from memory stage
        end
        alu_rr(3'b000, 1'b1, 3, 1, 2);
        store_word("sub", 3);
        alu_rr(3'b101, 1'b1, 3, 1, 2);
        store_word("sra", 3);
        for (int f = 0; f < 8; f++) begin
            alu_ri(3'(f), i_imm[f], 4, 1);
            store_word({r_names[f], "i"}, 4);
        end
        alu_ri(3'b101, 12'h413, 4, 1);  // SRAI by 19
        store_word("srai", 4);
        // Forwarding from each stage and the register-file bypass
        alu_ri(3'b000, 12'h2a5, 5, 0);
        alu_ri(3'b000, 12'h011, 6, 5);  // Memory stage
        alu_ri(3'b000, 12'hf00, 7, 5);  // MEM/WB
        alu_rr(3'b000, 1'b0, 8, 5, 6);  // Bypass for x5, MEM/WB for x6
        store_word("fwd_mem", 6);
        store_word("fwd_wb", 7);
        store_word("fwd_bypass", 8);
        // Load result used by the next instruction
        load_word(9, 12'h008);
        alu_rr(3'b000, 1'b0, 10, 9, 1);
        store_word("load_use", 10);
        load_upper(11, 20'habcde);
        store_word("lui", 11);
        alu_ri(3'b000, 12'h7ff, 0, 1);
        store_word("x0_write", 0);
        put_instr(32'h0000_0617);       // AUIPC x12 runs as a NOP
        store_word("unknown_op", 12);
    endtask

    // Sampled on the falling edge, away from register updates
    initial begin
        @(posedge clk);  // First edge puts the DUT in reset
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                assert (!dmem_req.we && !dmem_req.re)
                    else report_error("memory enable asserted during reset");
                assert (instr_addr == `RV_RESET_PC)
                    else report_mismatch("reset_pc", `RV_RESET_PC, instr_addr);
                pc_exp = `RV_RESET_PC;
                cyc    = 0;
            end else begin
                assert (instr_addr == pc_exp)
                    else report_mismatch("pc_step", pc_exp, instr_addr);
                if (cyc < 3) begin
                    assert (!dmem_req.we && !dmem_req.re)
                        else report_error("memory enable asserted before the first instruction");
                end
                if (dmem_req.we) begin
                    assert (exp_addr_q.size() > 0)
                        else report_error("store seen when no store was expected");
                    assert (dmem_req.addr == exp_addr_q[0])
                        else report_mismatch({exp_name_q[0], " address"}, exp_addr_q[0],
                                             dmem_req.addr);
                    assert (dmem_req.wdata == exp_data_q[0])
                        else report_mismatch(exp_name_q[0], exp_data_q[0], dmem_req.wdata);
                    void'(exp_name_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
                pc_exp = pc_exp + 32'd4;
                cyc++;
            end
        end
    end

    initial begin
        seed = 32'hb1c3;
        for (int i = 0; i < 128; i++) begin
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < 16; i++) begin
            xreg[i] = '0;
        end
        st_off = ST_BASE;
        build_program();
        build_done = 1'b1;
        wait (rst_n === 1'b1);
        // Last instruction leaves the memory stage four fetches after the end
        wait (instr_addr == `RV_RESET_PC + 32'(4 * (prog_len + 4)));
        @(negedge clk);
        if (exp_addr_q.size() != 0) begin
            report_error($sformatf("%0d expected stores never reached memory",
                                   exp_addr_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog, reset time plus program length plus 20 spare cycles
    initial begin
        wait (build_done);
        #((prog_len + 28) * CLK_PERIOD);
        report_error("timeout, the program did not finish in time");
    end

endmodule
